// ==== dcache_top.f ====
+incdir+.
dcache_pkg.sv
dcache_req_port.sv
dcache_ways.sv
dcache_mem_port.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - include_dirs:
      - .
    files:
      - dcache_pkg.sv
      - dcache_req_port.sv
      - dcache_ways.sv
      - dcache_mem_port.sv
      - dcache_ctrl.sv
      - dcache_top.sv
      - target: test
        files:
          - tb_dcache.sv

// ==== tb_dcache_ref.svh ====
// testbench reference: golden memory model, memory fill pattern, lfsr and typed compare tasks
`ifndef TB_DCACHE_REF_SVH
`define TB_DCACHE_REF_SVH

localparam logic [31:0] LFSR_SEED = 32'h09e8_f23b;

// every cpu store lands here first
logic [`DC_WORD_W-1:0] golden [logic [`DC_WORD_W-1:0]];

// untouched memory content, every address bit matters
function automatic logic [`DC_WORD_W-1:0] init_word(input logic [`DC_WORD_W-1:0] a);
   return (a ^ 32'hc3a5_0f1e) + {a[7:0], a[31:8]};
endfunction

// expected read value, or expected final memory word
// a store updates the golden copy before the cache sees it
function automatic logic [`DC_WORD_W-1:0] golden_access(input logic wr,
      input logic [`DC_WORD_W-1:0] a, input logic [`DC_WORD_W-1:0] d);
   if (wr) begin
      golden[a] = d;
   end
   return golden.exists(a) ? golden[a] : init_word(a);
endfunction

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one step per bit taken, newest bit at bit 0
task automatic draw_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
   v = '0;
   for (int i = 0; i < n; i++) begin
      st = lfsr_step(st);
      v  = {v[30:0], st[0]};
   end
endtask

// data word compare
task automatic check_word(input string name, input logic [`DC_WORD_W-1:0] got,
      input logic [`DC_WORD_W-1:0] exp_w);
   chk_count++;
   if (got !== exp_w) begin
      err_count++;
      $display("FAILED %s: got %h, expected %h", name, got, exp_w);
   end
endtask

// bus address compare, flat word shown
task automatic check_addr(input string name, input dcache_addr_u got, input dcache_addr_u exp_a);
   chk_count++;
   if (got.word !== exp_a.word) begin
      err_count++;
      $display("FAILED %s: got %h, expected %h", name, got.word, exp_a.word);
   end
endtask

`endif

// ==== tb_dcache.sv ====
// data cache testbench: clock, reset, DUT, memory responder, directed and random tests, watchdog
`default_nettype none

`include "dcache_settings.svh"

module tb_dcache import dcache_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_RAND    = 48;
   // directed, random, and one per line for the flush walk
   localparam int N_ACCESS  = 10 + N_RAND + 2 * `DC_SETS;
   localparam int ACC_LIMIT = 64;
   localparam int CYC_LIMIT = ACC_LIMIT * N_ACCESS + 8;

   logic CLK = 1'b0;
   logic nRST, req, ren, wen, halt, mem_wait;
   logic [`DC_WORD_W-1:0] addr, wdata, mem_rdata;
   logic ack, flushed, mem_ren, mem_wen;
   logic [`DC_WORD_W-1:0] rdata, mem_addr, mem_wdata;

   int err_count;
   int chk_count;
   int cycles;
   bit ack_seen;
   // responder backing store, written words only
   logic [`DC_WORD_W-1:0] mem_model [logic [`DC_WORD_W-1:0]];
   // one entry per access in flight
   logic [`DC_WORD_W-1:0] exp_q[$];
   logic [`DC_WORD_W-1:0] exp_addr_q[$];
   bit                    exp_rd_q[$];

   `include "tb_dcache_ref.svh"

   always #2 CLK = ~CLK;

   dcache_top dcache_top_inst (.*);

   function automatic logic [`DC_WORD_W-1:0] mem_word(input logic [`DC_WORD_W-1:0] a);
      return mem_model.exists(a) ? mem_model[a] : init_word(a);
   endfunction

   function automatic logic [`DC_WORD_W-1:0] make_addr(input logic [`DC_TAG_W-1:0] tg,
         input logic [`DC_IDX_W-1:0] ix, input logic [`DC_BLK_W-1:0] bk);
      dcache_addr_u a;
      a.word  = '0;
      a.f.tag = tg;
      a.f.idx = ix;
      a.f.blk = bk;
      return a.word;
   endfunction

   task automatic report_test(input int num, input string name, input int err_before);
      if (err_count == err_before) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: %0d errors", num, name, err_count - err_before);
      end
   endtask

   // one four-phase cycle, entered and left just after a rising edge
   // lat counts edges from the sampling edge to ack
   task automatic cpu_access(input logic wr, input logic [`DC_WORD_W-1:0] a,
         input logic [`DC_WORD_W-1:0] d, output int lat);
      exp_q.push_back(golden_access(wr, a, d));
      exp_addr_q.push_back(a);
      exp_rd_q.push_back(!wr);
      req   = 1'b1;
      ren   = !wr;
      wen   = wr;
      addr  = a;
      wdata = d;
      @(posedge CLK);
      lat = 0;
      do begin
         @(posedge CLK);
         #1;
         lat++;
      end while (!ack && lat < ACC_LIMIT);
      if (!ack) begin
         err_count++;
         $display("no ack within %0d cycles for address %h", ACC_LIMIT, a);
      end
      req = 1'b0;
      ren = 1'b0;
      wen = 1'b0;
      while (ack) begin
         @(posedge CLK);
         #1;
      end
   endtask

   // rdata checked mid-cycle while ack is high
   always @(negedge CLK) begin
      if (ack && !ack_seen && exp_q.size() > 0) begin
         if (exp_rd_q[0]) begin
            check_word($sformatf("rdata[%h]", exp_addr_q[0]), rdata, exp_q[0]);
         end
         void'(exp_q.pop_front());
         void'(exp_addr_q.pop_front());
         void'(exp_rd_q.pop_front());
      end
      ack_seen = ack;
   end

   // memory responder: random stalls, burst address check, store on accepted write
   initial begin
      logic [31:0]  st, bits;
      dcache_addr_u got, exp_a, base;
      bit           beat;
      st        = LFSR_SEED;
      beat      = 1'b0;
      base      = '0;
      mem_wait  = 1'b0;
      mem_rdata = '0;
      forever begin
         @(posedge CLK);
         #1;
         draw_bits(st, 2, bits);
         // roughly one stall in four
         mem_wait  = &bits[1:0];
         got.word  = mem_addr;
         mem_rdata = mem_ren ? mem_word(mem_addr) : '0;
         if (mem_ren && mem_wen) begin
            err_count++;
            $display("memory read and write requested in the same cycle");
         end
         if ((mem_ren || mem_wen) && !mem_wait) begin
            // first word block-aligned, second one word above it
            exp_a = got;
            if (!beat) begin
               // a fill fetches the block of the access in flight
               if (mem_ren && exp_addr_q.size() > 0) begin
                  exp_a.word = exp_addr_q[0];
               end
               exp_a.f.blk = '0;
               exp_a.f.byt = '0;
               base        = exp_a;
            end else begin
               exp_a       = base;
               exp_a.f.blk = '1;
            end
            check_addr("mem_addr", got, exp_a);
            if (mem_wen) begin
               mem_model[mem_addr] = mem_wdata;
            end
            beat = !beat;
         end
      end
   end

   // watchdog sized from the access count
   initial begin
      cycles = 0;
      while (cycles < CYC_LIMIT) begin
         @(posedge CLK);
         cycles++;
      end
      $display("run stopped after %0d cycles without finishing", cycles);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      int                    lat, base_err;
      logic                  wr;
      logic [31:0]           st, bits, d;
      logic [`DC_WORD_W-1:0] a;
      st    = LFSR_SEED;
      nRST  = 1'b0;
      req   = 1'b0;
      ren   = 1'b0;
      wen   = 1'b0;
      addr  = '0;
      wdata = '0;
      halt  = 1'b0;
      repeat (8) @(posedge CLK);
      #1;
      nRST = 1'b1;

      base_err = err_count;
      check_word("ack", 32'(ack), '0);
      check_word("mem_ren", 32'(mem_ren), '0);
      check_word("mem_wen", 32'(mem_wen), '0);
      check_word("flushed", 32'(flushed), '0);
      report_test(1, "reset state", base_err);

      // cold miss, then a hit to the same word
      base_err = err_count;
      cpu_access(1'b0, 32'h0000_1040, '0, lat);
      cpu_access(1'b0, 32'h0000_1040, '0, lat);
      if (lat != 2) begin
         err_count++;
         $display("hit answered after %0d cycles instead of 2", lat);
      end
      report_test(2, "read miss and hit", base_err);

      // write-allocate, neighbour word comes from the fill
      base_err = err_count;
      cpu_access(1'b1, 32'h0000_2088, 32'h5e1f_37a2, lat);
      cpu_access(1'b0, 32'h0000_2088, '0, lat);
      cpu_access(1'b0, 32'h0000_208c, '0, lat);
      report_test(3, "write then read", base_err);

      // three tags in set 5, the dirty victim must come back from memory
      base_err = err_count;
      for (int i = 0; i < 3; i++) begin
         cpu_access(i < 2, make_addr(26'h300 + 26'(i), 3'd5, 1'b1), 32'ha500_7100 + i, lat);
      end
      cpu_access(1'b0, make_addr(26'h300, 3'd5, 1'b1), '0, lat);
      cpu_access(1'b0, make_addr(26'h301, 3'd5, 1'b1), '0, lat);
      report_test(4, "eviction and write-back", base_err);

      // four tags per set keep both ways under pressure
      base_err = err_count;
      for (int n = 0; n < N_RAND; n++) begin
         draw_bits(st, 1, bits);
         wr = bits[0];
         draw_bits(st, 6, bits);
         a = make_addr(26'h300 + 26'(bits[5:4]), bits[3:1], bits[0]);
         draw_bits(st, 32, d);
         cpu_access(wr, a, d, lat);
      end
      report_test(5, "random accesses", base_err);

      // flush walk, then memory must hold every stored word
      base_err = err_count;
      halt = 1'b1;
      lat  = 0;
      while (!flushed && lat < ACC_LIMIT * 2 * `DC_SETS) begin
         @(posedge CLK);
         #1;
         lat++;
      end
      if (!flushed) begin
         err_count++;
         $display("flushed did not rise after halt");
      end
      foreach (golden[k]) begin
         check_word($sformatf("mem[%h]", k), mem_word(k), golden[k]);
      end
      report_test(6, "halt and flush", base_err);

      $display("tests: 6, checks: %0d, errors: %0d", chk_count, err_count);
      if (err_count == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
// data cache top level: request port, control, ways and memory port instances
`default_nettype none

`include "dcache_settings.svh"

module dcache_top import dcache_pkg::*; (
   input  logic                  CLK,
   input  logic                  nRST,
   input  logic                  req,
   input  logic                  ren,
   input  logic                  wen,
   input  logic [`DC_WORD_W-1:0] addr,
   input  logic [`DC_WORD_W-1:0] wdata,
   output logic                  ack,
   output logic [`DC_WORD_W-1:0] rdata,
   input  logic                  halt,
   output logic                  flushed,
   output logic                  mem_ren,
   output logic                  mem_wen,
   output logic [`DC_WORD_W-1:0] mem_addr,
   output logic [`DC_WORD_W-1:0] mem_wdata,
   input  logic [`DC_WORD_W-1:0] mem_rdata,
   input  logic                  mem_wait
);

   // request port to control and ways
   logic                  start, is_write, done;
   dcache_addr_u          req_addr;
   logic [`DC_WORD_W-1:0] req_wdata;
   // control and ways
   logic [`DC_IDX_W-1:0]  lk_idx;
   logic                  hit, hit_way, victim_dirty;
   logic [`DC_TAG_W-1:0]  victim_tag;
   logic [`DC_WORD_W-1:0] line_w0, line_w1;
   logic                  fill_en, store_en, sel_way, clear_dirty;
   // control and memory port
   logic                  burst_start, burst_write, burst_done;
   dcache_addr_u          burst_addr;
   logic [`DC_WORD_W-1:0] burst_w0, burst_w1, fill_w0, fill_w1;

   dcache_req_port req_port_inst (
      .CLK(CLK), .nRST(nRST), .req(req), .ren(ren), .wen(wen), .addr(addr), .wdata(wdata),
      .start(start), .is_write(is_write), .req_addr(req_addr), .req_wdata(req_wdata),
      .done(done), .ack(ack)
   );

   dcache_ctrl ctrl_inst (
      .CLK(CLK), .nRST(nRST), .start(start), .is_write(is_write), .req_addr(req_addr),
      .req_wdata(req_wdata), .halt(halt), .done(done), .flushed(flushed), .lk_idx(lk_idx),
      .hit(hit), .hit_way(hit_way), .victim_dirty(victim_dirty), .victim_tag(victim_tag),
      .line_w0(line_w0), .line_w1(line_w1), .fill_en(fill_en), .store_en(store_en),
      .sel_way(sel_way), .clear_dirty(clear_dirty), .burst_start(burst_start),
      .burst_write(burst_write), .burst_addr(burst_addr), .burst_w0(burst_w0),
      .burst_w1(burst_w1), .burst_done(burst_done)
   );

   dcache_ways ways_inst (
      .CLK(CLK), .nRST(nRST), .lk_idx(lk_idx), .req_addr(req_addr), .req_wdata(req_wdata),
      .fill_en(fill_en), .store_en(store_en), .sel_way(sel_way), .clear_dirty(clear_dirty),
      .fill_w0(fill_w0), .fill_w1(fill_w1), .hit(hit), .hit_way(hit_way),
      .victim_dirty(victim_dirty), .victim_tag(victim_tag), .line_w0(line_w0),
      .line_w1(line_w1), .rdata(rdata)
   );

   dcache_mem_port mem_port_inst (
      .CLK(CLK), .nRST(nRST), .burst_start(burst_start), .burst_write(burst_write),
      .burst_addr(burst_addr), .burst_w0(burst_w0), .burst_w1(burst_w1),
      .burst_done(burst_done), .fill_w0(fill_w0), .fill_w1(fill_w1), .mem_ren(mem_ren),
      .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .mem_rdata(mem_rdata), .mem_wait(mem_wait)
   );

endmodule

`default_nettype wire

// ==== dcache_ctrl.sv ====
// data cache control FSM: lookup, write-back, fill, store merge, respond and flush walk
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl import dcache_pkg::*; (
   input  logic                  CLK,
   input  logic                  nRST,
   input  logic                  start,
   input  logic                  is_write,
   input  dcache_addr_u          req_addr,
   input  logic [`DC_WORD_W-1:0] req_wdata,
   input  logic                  halt,
   output logic                  done,
   output logic                  flushed,
   output logic [`DC_IDX_W-1:0]  lk_idx,
   input  logic                  hit,
   input  logic                  hit_way,
   input  logic                  victim_dirty,
   input  logic [`DC_TAG_W-1:0]  victim_tag,
   input  logic [`DC_WORD_W-1:0] line_w0,
   input  logic [`DC_WORD_W-1:0] line_w1,
   output logic                  fill_en,
   output logic                  store_en,
   output logic                  sel_way,
   output logic                  clear_dirty,
   output logic                  burst_start,
   output logic                  burst_write,
   output dcache_addr_u          burst_addr,
   output logic [`DC_WORD_W-1:0] burst_w0,
   output logic [`DC_WORD_W-1:0] burst_w1,
   input  logic                  burst_done
);

   localparam logic [3:0] S_IDLE    = 4'd0;
   localparam logic [3:0] S_LOOKUP  = 4'd1;
   localparam logic [3:0] S_WB      = 4'd2;
   localparam logic [3:0] S_FILL    = 4'd3;
   localparam logic [3:0] S_MERGE   = 4'd4;
   localparam logic [3:0] S_RESPOND = 4'd5;
   localparam logic [3:0] S_FL_CHK  = 4'd6;
   localparam logic [3:0] S_FL_WB   = 4'd7;
   localparam logic [3:0] S_FL_DONE = 4'd8;

   logic [3:0]           state_q, state_d;
   // flush position, {set, way}
   logic [`DC_IDX_W:0]   walk_q, walk_d;
   logic                 way_q;
   logic                 flushing;
   logic                 walk_last;
   logic                 same_word;
   dcache_addr_u         wb_addr;
   dcache_addr_u         fill_addr;

   assign flushing  = (state_q == S_FL_CHK) || (state_q == S_FL_WB);
   assign walk_last = &walk_q;
   assign flushed   = (state_q == S_FL_DONE);

   assign lk_idx = flushing ? walk_q[`DC_IDX_W:1] : req_addr.f.idx;

   // lookup picks its own way, miss path keeps the one latched there
   always_comb begin
      case (state_q)
         S_LOOKUP:                  sel_way = hit_way;
         S_FL_CHK, S_FL_WB:         sel_way = walk_q[0];
         default:                   sel_way = way_q;
      endcase
   end

   // store of an unchanged word leaves the line clean
   assign same_word = (req_addr.f.blk ? line_w1 : line_w0) == req_wdata;

   // victim line address from its tag, block-aligned fill address
   always_comb begin
      wb_addr       = '0;
      wb_addr.f.tag = victim_tag;
      wb_addr.f.idx = lk_idx;
      fill_addr       = req_addr;
      fill_addr.f.blk = '0;
      fill_addr.f.byt = '0;
   end

   assign burst_write = (state_q == S_LOOKUP && victim_dirty) || state_q == S_FL_CHK;
   assign burst_addr  = burst_write ? wb_addr : fill_addr;
   assign burst_w0    = line_w0;
   assign burst_w1    = line_w1;

   always_comb begin
      state_d     = state_q;
      walk_d      = walk_q;
      done        = 1'b0;
      fill_en     = 1'b0;
      store_en    = 1'b0;
      clear_dirty = 1'b0;
      burst_start = 1'b0;
      case (state_q)
         S_IDLE: begin
            if (start) begin
               state_d = S_LOOKUP;
            end else if (halt) begin
               state_d = S_FL_CHK;
            end
         end
         S_LOOKUP: begin
            if (hit) begin
               // hit finishes here, ack follows next edge
               done     = 1'b1;
               store_en = is_write && !same_word;
               state_d  = S_IDLE;
            end else begin
               burst_start = 1'b1;
               state_d     = victim_dirty ? S_WB : S_FILL;
            end
         end
         S_WB: begin
            // old line out, then fetch the new one
            if (burst_done) begin
               burst_start = 1'b1;
               state_d     = S_FILL;
            end
         end
         S_FILL: begin
            if (burst_done) begin
               fill_en = 1'b1;
               state_d = is_write ? S_MERGE : S_RESPOND;
            end
         end
         S_MERGE: begin
            store_en = !same_word;
            state_d  = S_RESPOND;
         end
         S_RESPOND: begin
            done    = 1'b1;
            state_d = S_IDLE;
         end
         S_FL_CHK: begin
            if (victim_dirty) begin
               burst_start = 1'b1;
               state_d     = S_FL_WB;
            end else if (walk_last) begin
               state_d = S_FL_DONE;
            end else begin
               walk_d = walk_q + 1'b1;
            end
         end
         S_FL_WB: begin
            if (burst_done) begin
               clear_dirty = 1'b1;
               walk_d      = walk_q + 1'b1;
               state_d     = walk_last ? S_FL_DONE : S_FL_CHK;
            end
         end
         // flushed holds until reset
         default: state_d = state_q;
      endcase
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         state_q <= S_IDLE;
         walk_q  <= '0;
         way_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         walk_q  <= walk_d;
         if (state_q == S_LOOKUP) begin
            way_q <= hit_way;
         end
      end
   end

endmodule

`default_nettype wire

// ==== dcache_mem_port.sv ====
// data cache memory side: two-word burst sequencer with wait handling and fill capture
`default_nettype none

`include "dcache_settings.svh"

module dcache_mem_port import dcache_pkg::*; (
   input  logic                  CLK,
   input  logic                  nRST,
   input  logic                  burst_start,
   input  logic                  burst_write,
   input  dcache_addr_u          burst_addr,
   input  logic [`DC_WORD_W-1:0] burst_w0,
   input  logic [`DC_WORD_W-1:0] burst_w1,
   output logic                  burst_done,
   output logic [`DC_WORD_W-1:0] fill_w0,
   output logic [`DC_WORD_W-1:0] fill_w1,
   output logic                  mem_ren,
   output logic                  mem_wen,
   output logic [`DC_WORD_W-1:0] mem_addr,
   output logic [`DC_WORD_W-1:0] mem_wdata,
   input  logic [`DC_WORD_W-1:0] mem_rdata,
   input  logic                  mem_wait
);

   logic                 busy_q;
   logic                 write_q;
   logic [`DC_BLK_W-1:0] beat_q;
   dcache_addr_u         base_q;
   dcache_addr_u         beat_addr;
   logic [`DC_WORD_W-1:0] w0_q, w1_q;
   logic                 accept;
   logic                 last;

   // word taken when wait is low
   assign accept = busy_q && !mem_wait;
   assign last   = (beat_q == '1);

   // block base plus current word
   always_comb begin
      beat_addr       = base_q;
      beat_addr.f.blk = beat_q;
      beat_addr.f.byt = '0;
   end

   assign mem_addr  = beat_addr.word;
   assign mem_wdata = (beat_q == '0) ? w0_q : w1_q;
   assign mem_ren   = busy_q && !write_q;
   assign mem_wen   = busy_q && write_q;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         busy_q     <= 1'b0;
         write_q    <= 1'b0;
         beat_q     <= '0;
         burst_done <= 1'b0;
      end else begin
         // one cycle after the second word
         burst_done <= accept && last;
         if (burst_start) begin
            busy_q  <= 1'b1;
            write_q <= burst_write;
            beat_q  <= '0;
         end else if (accept) begin
            beat_q <= beat_q + 1'b1;
            if (last) begin
               busy_q <= 1'b0;
            end
         end
      end
   end

   // burst payload and returned words
   always_ff @(posedge CLK) begin
      if (burst_start) begin
         base_q <= burst_addr;
         w0_q   <= burst_w0;
         w1_q   <= burst_w1;
      end
      if (accept && !write_q) begin
         if (beat_q == '0) begin
            fill_w0 <= mem_rdata;
         end else begin
            fill_w1 <= mem_rdata;
         end
      end
   end

endmodule

`default_nettype wire

// ==== dcache_ways.sv ====
// data cache storage: two ways of tag, data, valid, dirty, per-set lru, hit compare, line write
`default_nettype none

`include "dcache_settings.svh"

module dcache_ways import dcache_pkg::*; (
   input  logic                  CLK,
   input  logic                  nRST,
   input  logic [`DC_IDX_W-1:0]  lk_idx,
   input  dcache_addr_u          req_addr,
   input  logic [`DC_WORD_W-1:0] req_wdata,
   input  logic                  fill_en,
   input  logic                  store_en,
   input  logic                  sel_way,
   input  logic                  clear_dirty,
   input  logic [`DC_WORD_W-1:0] fill_w0,
   input  logic [`DC_WORD_W-1:0] fill_w1,
   output logic                  hit,
   output logic                  hit_way,
   output logic                  victim_dirty,
   output logic [`DC_TAG_W-1:0]  victim_tag,
   output logic [`DC_WORD_W-1:0] line_w0,
   output logic [`DC_WORD_W-1:0] line_w1,
   output logic [`DC_WORD_W-1:0] rdata
);

   // payload arrays
   logic [`DC_TAG_W-1:0]  tag_q  [`DC_WAYS][`DC_SETS];
   logic [`DC_WORD_W-1:0] data_q [`DC_WAYS][`DC_SETS][2**`DC_BLK_W];

   // line state
   logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid_q;
   logic [`DC_WAYS-1:0][`DC_SETS-1:0] dirty_q;
   // way to evict next, per set
   logic [`DC_SETS-1:0] lru_q;

   logic repl_way;
   logic used_way;

   // empty way first, else least recently used
   assign repl_way = !valid_q[0][lk_idx] ? 1'b0 :
                     !valid_q[1][lk_idx] ? 1'b1 : lru_q[lk_idx];

   // tag compare across both ways
   // on a miss hit_way names the replacement way
   always_comb begin
      hit     = 1'b0;
      hit_way = repl_way;
      for (int w = 0; w < `DC_WAYS; w++) begin
         if (valid_q[w][lk_idx] && tag_q[w][lk_idx] == req_addr.f.tag) begin
            hit     = 1'b1;
            hit_way = 1'(w);
         end
      end
   end

   // selected line, for write-back and store compare
   assign victim_dirty = valid_q[sel_way][lk_idx] && dirty_q[sel_way][lk_idx];
   assign victim_tag   = tag_q[sel_way][lk_idx];
   assign line_w0      = data_q[sel_way][lk_idx][0];
   assign line_w1      = data_q[sel_way][lk_idx][1];

   // cpu read word
   assign rdata = data_q[hit_way][lk_idx][req_addr.f.blk];

   // fill takes the chosen way, a hit touches its own
   assign used_way = fill_en ? sel_way : hit_way;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         valid_q <= '0;
         dirty_q <= '0;
         lru_q   <= '0;
      end else begin
         if (fill_en) begin
            // fresh line from memory is clean
            valid_q[sel_way][lk_idx] <= 1'b1;
            dirty_q[sel_way][lk_idx] <= 1'b0;
         end else if (store_en) begin
            dirty_q[sel_way][lk_idx] <= 1'b1;
         end else if (clear_dirty) begin
            dirty_q[sel_way][lk_idx] <= 1'b0;
         end
         // other way becomes the next victim
         if (fill_en || hit) begin
            lru_q[lk_idx] <= ~used_way;
         end
      end
   end

   // tag and data writes
   always_ff @(posedge CLK) begin
      if (fill_en) begin
         tag_q[sel_way][lk_idx]     <= req_addr.f.tag;
         data_q[sel_way][lk_idx][0] <= fill_w0;
         data_q[sel_way][lk_idx][1] <= fill_w1;
      end else if (store_en) begin
         data_q[sel_way][lk_idx][req_addr.f.blk] <= req_wdata;
      end
   end

endmodule

`default_nettype wire

// ==== dcache_req_port.sv ====
// data cache cpu side: four-phase req/ack capture and address decode
`default_nettype none

`include "dcache_settings.svh"

module dcache_req_port import dcache_pkg::*; (
   input  logic                  CLK,
   input  logic                  nRST,
   input  logic                  req,
   input  logic                  ren,
   input  logic                  wen,
   input  logic [`DC_WORD_W-1:0] addr,
   input  logic [`DC_WORD_W-1:0] wdata,
   output logic                  start,
   output logic                  is_write,
   output dcache_addr_u          req_addr,
   output logic [`DC_WORD_W-1:0] req_wdata,
   input  logic                  done,
   output logic                  ack
);

   logic req_q;
   logic new_req;

   // rising edge of req, only once the last ack has dropped
   assign new_req = req && !req_q && !ack;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         req_q <= 1'b0;
         start <= 1'b0;
         ack   <= 1'b0;
      end else begin
         req_q <= req;
         // single pulse per request
         start <= new_req && (ren || wen);
         // ack held until cpu lets go of req
         if (done) begin
            ack <= 1'b1;
         end else if (!req) begin
            ack <= 1'b0;
         end
      end
   end

   // request payload, held for the whole access
   always_ff @(posedge CLK) begin
      if (new_req) begin
         req_addr.word <= addr;
         req_wdata     <= wdata;
         is_write      <= wen;
      end
   end

endmodule

`default_nettype wire

// ==== dcache_pkg.sv ====
// data cache package: address union type
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

   // one address word, seen flat or as lookup fields
   typedef struct packed {
      logic [`DC_TAG_W-1:0]  tag;
      logic [`DC_IDX_W-1:0]  idx;
      logic [`DC_BLK_W-1:0]  blk;
      logic [`DC_BYTE_W-1:0] byt;
   } dcache_addr_f_t;

   // flat view drives the memory bus, field view serves lookup
   typedef union packed {
      logic [`DC_WORD_W-1:0] word;
      dcache_addr_f_t        f;
   } dcache_addr_u;

endpackage

`default_nettype wire

// ==== dcache_settings.svh ====
// data cache sizing macros: word, tag, index, block and byte widths, set and way counts
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// data and address width
`define DC_WORD_W 32

// address split: tag | index | word in block | byte
`define DC_TAG_W  26
`define DC_IDX_W  3
`define DC_BLK_W  1
`define DC_BYTE_W 2

// geometry
`define DC_SETS   8
// fixed at two, one lru bit per set
`define DC_WAYS   2

`endif
